//--- verilog/heapPkg.sv
//--------------------------------------------------
// Shared codes for the array heap.
// Action codes, error codes and bus word addresses,
// imported by every heap module.
//--------------------------------------------------
`default_nettype none

package heapPkg;

  // ------------------------------------------------
  // Operation codes
  // ------------------------------------------------
  typedef enum logic [7:0] {
    actReset      = 8'd1,                        // Empty the whole heap
    actWrite      = 8'd2,                        // Store operand at index
    actRead       = 8'd3,                        // Fetch element at index
    actSize       = 8'd4,                        // Current array size
    actPush       = 8'd14,                       // Append at the end
    actPop        = 8'd15,                       // Remove from the end
    actAlloc      = 8'd18,                       // New array handle
    actFree       = 8'd19,                       // Return handle for reuse
    actAdd        = 8'd20,                       // Add and return new value
    actAddAfter   = 8'd21,                       // Add but return old value
    actSubtract   = 8'd22,                       // Subtract and return new value
    actSubAfter   = 8'd23,                       // Subtract but return old value
    actShiftLeft  = 8'd24,                       // Operand is the shift amount
    actShiftRight = 8'd25,
    actNot        = 8'd27,                       // Bitwise invert
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } heapAction;

  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                      // Handle never handed out
    errFreed        = 4'd2,                      // Handle handed back
    errOutOfBounds  = 4'd3,                      // Index at or past size
    errFull         = 4'd4,                      // Push on full array
    errEmpty        = 4'd5,                      // Pop on empty array
    errOutOfMemory  = 4'd6,                      // No handle left
    errBadAction    = 4'd7                       // Unknown code
  } heapError;

  typedef enum logic [2:0] {
    regOperand  = 3'd0,                          // Write only
    regLocation = 3'd1,                          // Array above index
    regAction   = 3'd2,                          // Write starts the action
    regResult   = 3'd3,                          // Read only
    regError    = 3'd4                           // Read only and zero extended
  } heapRegister;

endpackage

`default_nettype wire

//--- verilog/heapBusSlave.sv
//--------------------------------------------------
// Wishbone classic slave for the heap.
// Holds operand and location, launches each action
// and answers register reads.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapBusSlave import heapPkg::*; #(
  parameter int arrayBits = 2,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  heapRegister          adr,
  input  logic [dataBits-1:0]  writeData,
  input  logic                 done,         // Action finished
  input  logic [dataBits-1:0]  resultData,   // Word picked by adr
  output logic [dataBits-1:0]  readData,
  output logic                 ack,
  output logic                 start,        // One cycle launch pulse
  output heapAction            action,
  output logic [arrayBits-1:0] arrayNumber,
  output logic [indexBits-1:0] elementIndex,
  output logic [dataBits-1:0]  operand
);

  localparam logic [2:0] stIdle   = 3'd0;     // Waiting for a strobe
  localparam logic [2:0] stDecode = 3'd1;     // Strobe seen, decode access
  localparam logic [2:0] stReply  = 3'd2;     // Plain register access
  localparam logic [2:0] stBusy   = 3'd3;     // Action in progress
  localparam logic [2:0] stHold   = 3'd4;     // Wait for strobe to drop

  logic [2:0] state;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state        <= stIdle;
      ack          <= 1'b0;
      start        <= 1'b0;
      readData     <= '0;
      action       <= actReset;
      arrayNumber  <= '0;
      elementIndex <= '0;
      operand      <= '0;
    end else begin
      case (state)
        stIdle: if (cyc && stb) state <= stDecode;
        stDecode: begin
          if (we && adr == regOperand) operand <= writeData;
          if (we && adr == regLocation) begin
            arrayNumber  <= writeData[indexBits +: arrayBits]; // Handle above index
            elementIndex <= writeData[indexBits-1:0];
          end
          if (we && adr == regAction) begin
            action <= heapAction'(writeData[7:0]);  // Unknown codes kept as is
            start  <= 1'b1;
            state  <= stBusy;
          end else begin
            state <= stReply;
          end
        end
        stReply: begin
          readData <= resultData;
          ack      <= 1'b1;
          state    <= stHold;
        end
        stBusy: begin
          start <= 1'b0;
          if (done) begin                           // Ack the clock after done
            ack   <= 1'b1;
            state <= stHold;
          end
        end
        stHold: begin
          ack <= 1'b0;                              // Single cycle ack
          if (!stb) state <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Ack only inside an active bus cycle
  ackInCycle: assert property (@(posedge clock) disable iff (!resetN) ack |-> cyc && stb);

endmodule

`default_nettype wire

//--- verilog/heapAllocator.sv
//--------------------------------------------------
// Array handle bookkeeping. Tracks live handles,
// hands out new ones and reuses freed ones LIFO.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapAllocator import heapPkg::*; #(
  parameter int arrayBits = 2
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 start,
  input  heapAction            action,
  input  logic [arrayBits-1:0] arrayNumber,
  output heapError             accessError,  // State of addressed array
  output logic [arrayBits-1:0] allocResult,  // Handle Alloc would give
  output heapError             allocError,
  output logic                 clearSize,
  output logic [arrayBits-1:0] clearArray
);

  localparam int arrays = 2**arrayBits;

  logic [arrays-1:0]    allocated;            // One live bit per handle
  logic [arrayBits:0]   usedCount;            // Handles ever handed out
  logic [arrayBits:0]   stackDepth;           // Freed handles waiting
  logic [arrayBits-1:0] freeStack [arrays];
  logic [arrayBits-1:0] topIndex;
  logic                 writeback;            // Matches store writeback cycle
  logic                 allocOk;
  logic                 freeOk;

  assign topIndex = stackDepth[arrayBits-1:0] - 1'b1;

  always_comb begin
    if ({1'b0, arrayNumber} >= usedCount) accessError = errNotAllocated;
    else if (!allocated[arrayNumber]) accessError = errFreed;
    else accessError = errNone;
  end

  always_comb begin
    allocError = errNone;
    if (stackDepth != '0) begin
      allocResult = freeStack[topIndex];      // Most recently freed first
    end else if (usedCount < arrays) begin
      allocResult = usedCount[arrayBits-1:0];
    end else begin
      allocResult = '0;
      allocError  = errOutOfMemory;
    end
    if (action == actFree) allocError = accessError; // Double free refused
  end

  assign allocOk    = writeback && action == actAlloc && allocError == errNone;
  assign freeOk     = writeback && action == actFree && accessError == errNone;
  assign clearSize  = allocOk || (writeback && action == actReset);
  assign clearArray = allocResult;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      writeback  <= 1'b0;
      allocated  <= '0;
      usedCount  <= '0;
      stackDepth <= '0;
    end else begin
      writeback <= start;
      if (writeback && action == actReset) begin
        allocated  <= '0;
        usedCount  <= '0;
        stackDepth <= '0;
      end else if (allocOk) begin
        allocated[allocResult] <= 1'b1;
        if (stackDepth != '0) stackDepth <= stackDepth - 1'b1;
        else usedCount <= usedCount + 1'b1;
      end else if (freeOk) begin
        allocated[arrayNumber] <= 1'b0;
        stackDepth             <= stackDepth + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (freeOk) freeStack[stackDepth[arrayBits-1:0]] <= arrayNumber;
  end

  // Each handle can be on the stack at most once
  stackBound: assert property (@(posedge clock) disable iff (!resetN) stackDepth <= arrays);

endmodule

`default_nettype wire

//--- verilog/heapElementStore.sv
//--------------------------------------------------
// Element memory and array sizes. Runs each action
// as a read cycle and a writeback cycle and decides
// the final result and error.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapElementStore import heapPkg::*; #(
  parameter int arrayBits = 2,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 start,
  input  heapAction            action,
  input  logic [arrayBits-1:0] arrayNumber,
  input  logic [indexBits-1:0] elementIndex,
  input  logic [dataBits-1:0]  operand,
  input  heapError             accessError,
  input  logic [arrayBits-1:0] allocResult,
  input  heapError             allocError,
  input  logic                 clearSize,
  input  logic [arrayBits-1:0] clearArray,
  output logic                 done,
  output logic [dataBits-1:0]  result,
  output heapError             error
);

  localparam int arrays      = 2**arrayBits;
  localparam int arrayLength = 2**indexBits;

  logic [dataBits-1:0]  memory [arrays*arrayLength]; // Fixed block per array
  logic [indexBits:0]   sizes [arrays];
  logic [indexBits:0]   size;                 // Size of addressed array
  logic [indexBits-1:0] readIndex;
  logic [indexBits-1:0] writeIndex;
  logic                 reading;              // Writeback cycle follows
  logic [dataBits-1:0]  oldValue;
  logic [dataBits-1:0]  newValue;
  logic [dataBits-1:0]  nextResult;
  heapError             nextError;
  logic                 isArith;
  logic                 outOfBounds;
  logic                 storesElement;

  assign size        = sizes[arrayNumber];
  assign readIndex   = (action == actPop) ? size[indexBits-1:0] - 1'b1 : elementIndex;
  assign writeIndex  = (action == actPush) ? size[indexBits-1:0] : elementIndex;
  assign outOfBounds = accessError == errNone && {1'b0, elementIndex} >= size;

  always_comb begin
    case (action)
      actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft, actShiftRight,
      actNot, actOr, actXor, actAnd: isArith = 1'b1;
      default:                       isArith = 1'b0;
    endcase
  end

  assign storesElement = isArith || action == actWrite || action == actPush;

  // ------------------------------------------------
  // Element arithmetic
  // ------------------------------------------------
  always_comb begin
    case (action)
      actAdd, actAddAfter:      newValue = oldValue + operand;
      actSubtract, actSubAfter: newValue = oldValue - operand;
      actShiftLeft:             newValue = oldValue << operand;
      actShiftRight:            newValue = oldValue >> operand;
      actNot:                   newValue = ~oldValue;
      actOr:                    newValue = oldValue | operand;
      actXor:                   newValue = oldValue ^ operand;
      actAnd:                   newValue = oldValue & operand;
      default:                  newValue = operand; // Write and Push
    endcase
  end

  // ------------------------------------------------
  // Checks, all in one place
  // ------------------------------------------------
  always_comb begin
    nextError = accessError;
    case (action)
      actReset:          nextError = errNone;
      actAlloc, actFree: nextError = allocError; // Allocator decides these
      actWrite, actSize: nextError = accessError;
      actRead:           if (outOfBounds) nextError = errOutOfBounds;
      actPush: if (accessError == errNone && size == arrayLength) nextError = errFull;
      actPop:  if (accessError == errNone && size == '0) nextError = errEmpty;
      default: begin
        if (!isArith) nextError = errBadAction;
        else if (outOfBounds) nextError = errOutOfBounds;
      end
    endcase
  end

  always_comb begin
    case (action)
      actSize:                                   nextResult = dataBits'(size);
      actAlloc:                                  nextResult = dataBits'(allocResult);
      actWrite, actPush:                         nextResult = operand;
      actRead, actPop, actAddAfter, actSubAfter: nextResult = oldValue;
      actReset, actFree:                         nextResult = '0;
      default:                                   nextResult = newValue;
    endcase
    if (nextError != errNone) nextResult = '0; // Failed action returns zero
  end

  always_ff @(posedge clock) begin
    if (start) oldValue <= memory[{arrayNumber, readIndex}];
    if (reading && nextError == errNone && storesElement) begin
      memory[{arrayNumber, writeIndex}] <= newValue;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      reading <= 1'b0;
      done    <= 1'b0;
      result  <= '0;
      error   <= errNone;
      for (int i = 0; i < arrays; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      reading <= start;
      done    <= reading;
      if (reading) begin
        result <= nextResult;
        error  <= nextError;
      end
      if (clearSize) begin
        if (action == actReset) begin
          for (int i = 0; i < arrays; i++) begin
            sizes[i] <= '0;
          end
        end else begin
          sizes[clearArray] <= '0;            // Fresh handle starts empty
        end
      end else if (reading && nextError == errNone) begin
        case (action)
          actWrite: begin
            if ({1'b0, elementIndex} >= size) begin
              sizes[arrayNumber] <= {1'b0, elementIndex} + 1'b1;
            end
          end
          actPush:  sizes[arrayNumber] <= size + 1'b1;
          actPop:   sizes[arrayNumber] <= size - 1'b1;
          default:  ;
        endcase
      end
    end
  end

  // Size updates stay within the fixed block
  sizeBound: assert property (@(posedge clock) disable iff (!resetN) size <= arrayLength);

endmodule

`default_nettype wire

//--- verilog/heapResultRegs.sv
//--------------------------------------------------
// Result and error of the last action, kept for
// bus reads until the next action completes.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapResultRegs import heapPkg::*; #(
  parameter int dataBits = 16
) (
  input  logic                clock,
  input  logic                resetN,
  input  logic                done,
  input  logic [dataBits-1:0] result,
  input  heapError            error,
  input  heapRegister         adr,
  output logic [dataBits-1:0] resultData
);

  logic [dataBits-1:0] resultQ;
  heapError            errorQ;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      resultQ <= '0;                          // Reads zero after reset
      errorQ  <= errNone;
    end else if (done) begin
      resultQ <= result;
      errorQ  <= error;
    end
  end

  always_comb begin
    case (adr)
      regError: resultData = dataBits'(errorQ);
      default:  resultData = resultQ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/heapTop.sv
//--------------------------------------------------
// Array heap behind a Wishbone classic slave port.
// Sets the sizes and wires the four blocks.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapTop import heapPkg::*; #(
  parameter int arrayBits = 2,                // 2^arrayBits arrays
  parameter int indexBits = 3,                // 2^indexBits elements each
  parameter int dataBits  = 16                // Element and bus width
) (
  input  logic                clock,
  input  logic                resetN,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  heapRegister         adr,
  input  logic [dataBits-1:0] writeData,
  output logic [dataBits-1:0] readData,
  output logic                ack
);

  logic                 start;
  logic                 done;
  logic                 clearSize;
  heapAction            action;
  logic [arrayBits-1:0] arrayNumber;
  logic [arrayBits-1:0] allocResult;
  logic [arrayBits-1:0] clearArray;
  logic [indexBits-1:0] elementIndex;
  logic [dataBits-1:0]  operand;
  logic [dataBits-1:0]  result;
  logic [dataBits-1:0]  resultData;
  heapError             accessError;
  heapError             allocError;
  heapError             error;

  heapBusSlave #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) u_bus (
    .clock, .resetN, .cyc, .stb, .we, .adr, .writeData, .done, .resultData,
    .readData, .ack, .start, .action, .arrayNumber, .elementIndex, .operand
  );

  heapAllocator #(.arrayBits(arrayBits)) u_alloc (
    .clock, .resetN, .start, .action, .arrayNumber,
    .accessError, .allocResult, .allocError, .clearSize, .clearArray
  );

  heapElementStore #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) u_store (
    .clock, .resetN, .start, .action, .arrayNumber, .elementIndex, .operand,
    .accessError, .allocResult, .allocError, .clearSize, .clearArray,
    .done, .result, .error
  );

  heapResultRegs #(.dataBits(dataBits)) u_results (
    .clock, .resetN, .done, .result, .error, .adr, .resultData
  );

endmodule

`default_nettype wire

//--- bench/heapBenchTasks.svh
//--------------------------------------------------
// Bus access and compare tasks for the heap
// testbench. Included inside the bench module and
// uses its bus signals and size constants.
//--------------------------------------------------
`ifndef HEAP_BENCH_TASKS_SVH
`define HEAP_BENCH_TASKS_SVH

// Report what went wrong and end the run
task automatic stopWithFailure(input string reason);
  $display("%s", reason);
  $display("Test failed");
  $fatal(1, "Simulation stopped on the first error");
endtask

// ------------------------------------------------
// Wishbone classic master
// ------------------------------------------------
task automatic busAccess(input logic write, input heapRegister address,
                         input logic [dataBits-1:0] data,
                         output logic [dataBits-1:0] readBack);
  int waited;
  waited = 0;
  @(negedge clock);                         // Start of a new cycle
  cyc       = 1'b1;
  stb       = 1'b1;
  we        = write;
  adr       = address;
  writeData = data;
  @(negedge clock);
  while (!ack && waited < ackTimeout) begin
    waited++;
    @(negedge clock);
  end
  if (!ack) begin
    stopWithFailure($sformatf("No ack from the DUT within %0d cycles", ackTimeout));
  end else begin
    readBack = readData;                    // Stable between edges
    @(negedge clock);                       // Keep stb over the ack edge
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  end
endtask

task automatic busWrite(input heapRegister address, input logic [dataBits-1:0] data);
  logic [dataBits-1:0] unused;
  busAccess(1'b1, address, data, unused);
endtask

task automatic busRead(input heapRegister address, output logic [dataBits-1:0] data);
  busAccess(1'b0, address, '0, data);
endtask

// ------------------------------------------------
// Typed compares
// ------------------------------------------------
task automatic checkData(input string signalName, input logic [dataBits-1:0] actual,
                         input logic [dataBits-1:0] expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
             $time, signalName, actual, expected);
    stopWithFailure("Data word does not match");
  end
endtask

task automatic checkError(input string signalName, input heapError actual,
                          input heapError expected);
  if (actual !== expected) begin
    $display("CHECK FAILED at %0t ns: %s is %s (%0d), expected %s (%0d)",
             $time, signalName, actual.name(), actual, expected.name(), expected);
    stopWithFailure("Error code does not match");
  end
endtask

`endif

//--- bench/heapBench.sv
//--------------------------------------------------
// Testbench for the array heap. Applies a table of
// actions over the Wishbone port and checks result
// and error code of every step.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapBench import heapPkg::*; ();

  localparam int arrayBits   = 2;
  localparam int indexBits   = 3;
  localparam int dataBits    = 16;
  localparam int clockPeriod = 40;          // ns
  localparam int ackTimeout  = 20;          // Cycles per bus access

  logic                clock      = 1'b0;
  logic                tableReady = 1'b0;
  logic                resetN;
  logic                cyc;
  logic                stb;
  logic                we;
  heapRegister         adr;
  logic [dataBits-1:0] writeData;
  logic [dataBits-1:0] readData;
  logic                ack;

  // Stimulus table with one entry per step
  logic [7:0]           stepAction  [$];
  logic [arrayBits-1:0] stepArray   [$];
  logic [indexBits-1:0] stepIndex   [$];
  logic [dataBits-1:0]  stepOperand [$];
  logic [dataBits-1:0]  stepResult  [$];
  heapError             stepError   [$];

  `include "heapBenchTasks.svh"

  always #(clockPeriod / 2) clock = ~clock;

  heapTop #(.arrayBits(arrayBits), .indexBits(indexBits), .dataBits(dataBits)) u_dut (
    .clock, .resetN, .cyc, .stb, .we, .adr, .writeData, .readData, .ack
  );

  task automatic addStep(input logic [7:0] code, input int arrayId, input int element,
                         input logic [dataBits-1:0] value, input logic [dataBits-1:0] expected,
                         input heapError expectedError);
    stepAction.push_back(code);
    stepArray.push_back(arrayBits'(arrayId));
    stepIndex.push_back(indexBits'(element));
    stepOperand.push_back(value);
    stepResult.push_back(expected);
    stepError.push_back(expectedError);
  endtask

  // ------------------------------------------------
  // Action, array, index, operand, result, error
  // ------------------------------------------------
  task automatic buildTable();
    int k;
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0000, errNone);  // Fresh handles in order
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0001, errNone);
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0002, errNone);
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0003, errNone);
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0000, errOutOfMemory);
    addStep(actFree,     2, 0, 16'h0000, 16'h0000, errNone);
    addStep(actFree,     1, 0, 16'h0000, 16'h0000, errNone);
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0001, errNone);  // Last freed first
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0002, errNone);
    addStep(actWrite,    0, 3, 16'h1234, 16'h1234, errNone);  // Write extends size
    addStep(actSize,     0, 0, 16'h0000, 16'h0004, errNone);
    addStep(actRead,     0, 3, 16'h0000, 16'h1234, errNone);
    addStep(actRead,     0, 5, 16'h0000, 16'h0000, errOutOfBounds);
    for (k = 0; k < 8; k++) begin           // Fill array 1 to the length
      addStep(actPush, 1, 0, 16'h1000 + 16'(k), 16'h1000 + 16'(k), errNone);
    end
    addStep(actPush,     1, 0, 16'h1008, 16'h0000, errFull);
    addStep(actSize,     1, 0, 16'h0000, 16'h0008, errNone);
    for (k = 7; k >= 0; k--) begin          // Reverse order on the way out
      addStep(actPop, 1, 0, 16'h0000, 16'h1000 + 16'(k), errNone);
    end
    addStep(actPop,      1, 0, 16'h0000, 16'h0000, errEmpty);
    addStep(actAdd,        0, 3, 16'h0011, 16'h1245, errNone);  // Chain on 0x1234
    addStep(actAddAfter,   0, 3, 16'h0100, 16'h1245, errNone);  // Stores 0x1345
    addStep(actSubtract,   0, 3, 16'h0045, 16'h1300, errNone);
    addStep(actSubAfter,   0, 3, 16'h0300, 16'h1300, errNone);  // Stores 0x1000
    addStep(actShiftLeft,  0, 3, 16'h0002, 16'h4000, errNone);
    addStep(actShiftRight, 0, 3, 16'h0004, 16'h0400, errNone);
    addStep(actOr,         0, 3, 16'h00FF, 16'h04FF, errNone);
    addStep(actXor,        0, 3, 16'h0F0F, 16'h0BF0, errNone);
    addStep(actAnd,        0, 3, 16'h03FF, 16'h03F0, errNone);
    addStep(actNot,        0, 3, 16'h0000, 16'hFC0F, errNone);
    addStep(actRead,       0, 3, 16'h0000, 16'hFC0F, errNone);
    addStep(actFree,     3, 0, 16'h0000, 16'h0000, errNone);
    addStep(actRead,     3, 0, 16'h0000, 16'h0000, errFreed);
    addStep(actSize,     3, 0, 16'h0000, 16'h0000, errFreed);
    addStep(actWrite,    3, 0, 16'h5555, 16'h0000, errFreed);
    addStep(actPush,     3, 0, 16'h5555, 16'h0000, errFreed);
    addStep(actFree,     3, 0, 16'h0000, 16'h0000, errFreed);   // Double free
    addStep(8'd5,        0, 0, 16'h0000, 16'h0000, errBadAction);
    addStep(actReset,    0, 0, 16'h0000, 16'h0000, errNone);
    addStep(actAlloc,    0, 0, 16'h0000, 16'h0000, errNone);   // Heap empty again
    addStep(actSize,     0, 0, 16'h0000, 16'h0000, errNone);
    addStep(actPop,      0, 0, 16'h0000, 16'h0000, errEmpty);
    addStep(actRead,     2, 0, 16'h0000, 16'h0000, errNotAllocated);
    addStep(actWrite,    3, 1, 16'h7777, 16'h0000, errNotAllocated);
    addStep(actFree,     1, 0, 16'h0000, 16'h0000, errNotAllocated);
  endtask

  // Three writes launch the step and two reads check it
  task automatic runStep(input int i);
    logic [dataBits-1:0] word;
    busWrite(regOperand, stepOperand[i]);
    busWrite(regLocation, dataBits'({stepArray[i], stepIndex[i]}));
    busWrite(regAction, dataBits'(stepAction[i]));
    busRead(regResult, word);
    checkData($sformatf("readData (result of step %0d)", i), word, stepResult[i]);
    busRead(regError, word);
    checkError($sformatf("readData (error of step %0d)", i), heapError'(word[3:0]),
               stepError[i]);
    checkData($sformatf("readData (error upper bits of step %0d)", i), word >> 4, '0);
  endtask

  initial begin
    resetN    = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = regOperand;
    writeData = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (3) @(negedge clock);            // Three cycles in reset
    resetN = 1'b1;
    for (int i = 0; i < stepAction.size(); i++) begin
      runStep(i);
    end
    $display("Test completed successfully");
    $finish;
  end

  // Five accesses of up to eight cycles per step plus reset
  initial begin
    wait (tableReady);
    #(stepAction.size() * 5 * 8 * clockPeriod + 10 * clockPeriod);
    stopWithFailure("Watchdog expired before all steps were applied");
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
verilog/heapPkg.sv
verilog/heapBusSlave.sv
verilog/heapAllocator.sv
verilog/heapElementStore.sv
verilog/heapResultRegs.sv
verilog/heapTop.sv
bench/heapBench.sv
